//--- logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath and address width
`define MIPS_DATA_WIDTH 32

`define MIPS_REG_ADDR_WIDTH 5 // Register number field
`define MIPS_REG_COUNT 32     // Architectural registers, r0 hardwired

`define MIPS_RESET_PC 32'h0000_0000 // First fetch address
`define MIPS_PC_STEP 32'd4          // Bytes per instruction

`endif

//--- logic/mips_core.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_core (
    input  logic                          clock,
    input  logic                          reset,
    output logic [`MIPS_DATA_WIDTH-1:0]   imem_addr,
    input  logic [`MIPS_DATA_WIDTH-1:0]   imem_data,
    output mips_pipe_pkg::dmem_req_t      dmem_req,
    input  logic [`MIPS_DATA_WIDTH-1:0]   dmem_rdata
);

    logic [`MIPS_DATA_WIDTH-1:0] pc;
    logic [`MIPS_DATA_WIDTH-1:0] if_pc_plus4;
    mips_isa_pkg::instr_t        id_instr;      // IF/ID
    logic [`MIPS_DATA_WIDTH-1:0] id_pc_plus4;
    mips_pipe_pkg::ctrl_t        id_ctrl;
    logic [`MIPS_DATA_WIDTH-1:0] id_imm_ext;
    logic                        id_redirect;
    logic [`MIPS_DATA_WIDTH-1:0] id_target;
    logic [`MIPS_DATA_WIDTH-1:0] id_rs_reg;     // Straight from the register file
    logic [`MIPS_DATA_WIDTH-1:0] id_rt_reg;
    logic [`MIPS_DATA_WIDTH-1:0] id_rs_value;   // After ID bypass
    logic [`MIPS_DATA_WIDTH-1:0] id_rt_value;
    mips_pipe_pkg::fwd_sel_e     id_rs_sel;
    mips_pipe_pkg::fwd_sel_e     id_rt_sel;
    mips_pipe_pkg::fwd_sel_e     ex_rs_sel;
    mips_pipe_pkg::fwd_sel_e     ex_rt_sel;
    logic                        stall;
    logic                        store_fwd;
    mips_pipe_pkg::id_ex_t       id_ex_next;
    mips_pipe_pkg::id_ex_t       id_ex;
    mips_pipe_pkg::ex_me_t       ex_me_next;
    mips_pipe_pkg::ex_me_t       ex_me;
    mips_pipe_pkg::me_wb_t       me_wb;
    logic [`MIPS_DATA_WIDTH-1:0] me_store_data;
    logic [`MIPS_DATA_WIDTH-1:0] wb_data;

    // IF
    assign imem_addr   = pc;
    assign if_pc_plus4 = pc + `MIPS_PC_STEP;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin // Branch held in ID does not redirect yet
            pc <= id_redirect ? id_target : if_pc_plus4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            id_instr <= '0; // NOP
        end else if (!stall) begin
            id_instr <= mips_isa_pkg::instr_t'(imem_data); // Delay slot also lands here
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            id_pc_plus4 <= if_pc_plus4;
        end
    end

    // ID
    mips_regfile u_regfile (
        .clock   (clock),
        .reset   (reset),
        .rs_addr (id_instr.rs),
        .rt_addr (id_instr.rt),
        .rs_data (id_rs_reg),
        .rt_data (id_rt_reg),
        .wr_en   (me_wb.reg_write),
        .wr_addr (me_wb.dest),
        .wr_data (wb_data)
    );

    assign id_rs_value = mips_pipe_pkg::fwd_mux(id_rs_sel, id_rs_reg, ex_me.alu_result, wb_data);
    assign id_rt_value = mips_pipe_pkg::fwd_mux(id_rt_sel, id_rt_reg, ex_me.alu_result, wb_data);

    mips_decode u_decode (
        .instr    (id_instr),
        .pc_plus4 (id_pc_plus4),
        .rs_value (id_rs_value),
        .rt_value (id_rt_value),
        .ctrl     (id_ctrl),
        .imm_ext  (id_imm_ext),
        .redirect (id_redirect),
        .target   (id_target)
    );

    mips_hazard u_hazard (
        .id_rs     (id_instr.rs),
        .id_rt     (id_instr.rt),
        .id_ctrl   (id_ctrl),
        .id_ex     (id_ex),
        .ex_me     (ex_me),
        .me_wb     (me_wb),
        .stall     (stall),
        .id_rs_sel (id_rs_sel),
        .id_rt_sel (id_rt_sel),
        .ex_rs_sel (ex_rs_sel),
        .ex_rt_sel (ex_rt_sel),
        .store_fwd (store_fwd)
    );

    assign id_ex_next = '{ctrl: id_ctrl, rs: id_instr.rs, rt: id_instr.rt, rd: id_instr.rd,
                          rs_value: id_rs_value, rt_value: id_rt_value, imm_ext: id_imm_ext};

    always_ff @(posedge clock) begin
        id_ex <= id_ex_next;
        if (reset || stall) begin
            id_ex.ctrl <= '0; // Bubble into EX
        end
    end

    // EX
    mips_execute u_execute (
        .id_ex      (id_ex),
        .rs_sel     (ex_rs_sel),
        .rt_sel     (ex_rt_sel),
        .me_result  (ex_me.alu_result),
        .wb_data    (wb_data),
        .ex_me_next (ex_me_next)
    );

    always_ff @(posedge clock) begin
        ex_me <= ex_me_next;
        if (reset) begin
            ex_me.mem_read  <= 1'b0;
            ex_me.mem_write <= 1'b0;
            ex_me.reg_write <= 1'b0;
        end
    end

    // ME, a load directly ahead of a store supplies its data from WB
    assign me_store_data = store_fwd ? wb_data : ex_me.store_data;

    assign dmem_req = '{addr: ex_me.alu_result, wdata: me_store_data,
                        write: ex_me.mem_write, read: ex_me.mem_read};

    always_ff @(posedge clock) begin
        me_wb <= '{mem_to_reg: ex_me.mem_read, reg_write: ex_me.reg_write, dest: ex_me.dest,
                   mem_data: dmem_rdata, alu_result: ex_me.alu_result};
        if (reset) begin
            me_wb.reg_write <= 1'b0;
        end
    end

    // WB
    assign wb_data = me_wb.mem_to_reg ? me_wb.mem_data : me_wb.alu_result;

    // Decode never marks one instruction as both load and store
    assert property (@(posedge clock) disable iff (reset)
        !(dmem_req.write && dmem_req.read));

    // Worst case is a branch on a load still in EX
    assert property (@(posedge clock) disable iff (reset)
        stall [*2] |=> !stall);

endmodule

//--- logic/mips_decode.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_decode (
    input  mips_isa_pkg::instr_t          instr,
    input  logic [`MIPS_DATA_WIDTH-1:0]   pc_plus4,
    input  logic [`MIPS_DATA_WIDTH-1:0]   rs_value, // Forwarded operands
    input  logic [`MIPS_DATA_WIDTH-1:0]   rt_value,
    output mips_pipe_pkg::ctrl_t          ctrl,
    output logic [`MIPS_DATA_WIDTH-1:0]   imm_ext,
    output logic                          redirect,
    output logic [`MIPS_DATA_WIDTH-1:0]   target
);

    logic                        zero_ext;      // ANDI and ORI
    logic                        is_jump;
    logic                        take_branch;
    logic [`MIPS_DATA_WIDTH-1:0] branch_target;
    logic [`MIPS_DATA_WIDTH-1:0] jump_target;

    always_comb begin
        ctrl        = '0; // Unknown opcodes fall out as NOP
        zero_ext    = 1'b0;
        is_jump     = 1'b0;
        take_branch = 1'b0;
        case (instr.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                ctrl.reads_rs   = 1'b1;
                ctrl.reads_rt   = 1'b1;
                ctrl.dest_is_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (instr.funct)
                    mips_isa_pkg::FN_ADDU: ctrl.alu_op = mips_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: ctrl.alu_op = mips_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  ctrl.alu_op = mips_pipe_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   ctrl.alu_op = mips_pipe_pkg::ALU_OR;
                    mips_isa_pkg::FN_SLT:  ctrl.alu_op = mips_pipe_pkg::ALU_SLT;
                    default:               ctrl = '0; // SLL encoding, so NOP lands here
                endcase
            end
            mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI: begin
                ctrl.reads_rs  = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                if (instr.opcode == mips_isa_pkg::OP_ANDI) begin
                    ctrl.alu_op = mips_pipe_pkg::ALU_AND;
                    zero_ext    = 1'b1;
                end else if (instr.opcode == mips_isa_pkg::OP_ORI) begin
                    ctrl.alu_op = mips_pipe_pkg::ALU_OR;
                    zero_ext    = 1'b1;
                end
            end
            mips_isa_pkg::OP_LW: begin
                ctrl.reads_rs  = 1'b1;
                ctrl.alu_src   = 1'b1; // Address is rs plus offset
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::OP_SW: begin
                ctrl.reads_rs  = 1'b1;
                ctrl.reads_rt  = 1'b1; // Store data
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
                ctrl.reads_rs  = 1'b1;
                ctrl.reads_rt  = 1'b1;
                ctrl.is_branch = 1'b1;
                take_branch    = (rs_value == rt_value) ^ (instr.opcode == mips_isa_pkg::OP_BNE);
            end
            mips_isa_pkg::OP_J: is_jump = 1'b1;
            default: ;
        endcase
    end

    // Low half is the immediate whatever the format
    assign imm_ext = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // Same 256 MB region

    assign redirect = is_jump | take_branch;
    assign target   = is_jump ? jump_target : branch_target;

endmodule

//--- logic/mips_execute.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_execute (
    input  mips_pipe_pkg::id_ex_t        id_ex,
    input  mips_pipe_pkg::fwd_sel_e      rs_sel,
    input  mips_pipe_pkg::fwd_sel_e      rt_sel,
    input  logic [`MIPS_DATA_WIDTH-1:0]  me_result, // ALU result held in EX/ME
    input  logic [`MIPS_DATA_WIDTH-1:0]  wb_data,   // Value being written back
    output mips_pipe_pkg::ex_me_t        ex_me_next
);

    logic [`MIPS_DATA_WIDTH-1:0] alu_a;
    logic [`MIPS_DATA_WIDTH-1:0] rt_fwd;
    logic [`MIPS_DATA_WIDTH-1:0] alu_b;
    logic [`MIPS_DATA_WIDTH-1:0] alu_result;

    assign alu_a  = mips_pipe_pkg::fwd_mux(rs_sel, id_ex.rs_value, me_result, wb_data);
    assign rt_fwd = mips_pipe_pkg::fwd_mux(rt_sel, id_ex.rt_value, me_result, wb_data);
    assign alu_b  = id_ex.ctrl.alu_src ? id_ex.imm_ext : rt_fwd;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            mips_pipe_pkg::ALU_SUB: alu_result = alu_a - alu_b;
            mips_pipe_pkg::ALU_AND: alu_result = alu_a & alu_b;
            mips_pipe_pkg::ALU_OR:  alu_result = alu_a | alu_b;
            mips_pipe_pkg::ALU_SLT: alu_result = {31'd0, $signed(alu_a) < $signed(alu_b)};
            default:                alu_result = alu_a + alu_b; // Also address generation
        endcase
    end

    always_comb begin
        ex_me_next.mem_read   = id_ex.ctrl.mem_read;
        ex_me_next.mem_write  = id_ex.ctrl.mem_write;
        ex_me_next.reg_write  = id_ex.ctrl.reg_write;
        ex_me_next.dest       = id_ex.ctrl.dest_is_rd ? id_ex.rd : id_ex.rt;
        ex_me_next.alu_result = alu_result;
        ex_me_next.store_data = rt_fwd; // May still be replaced in ME
    end

endmodule

//--- logic/mips_hazard.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_hazard (
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] id_rs,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] id_rt,
    input  mips_pipe_pkg::ctrl_t            id_ctrl,
    input  mips_pipe_pkg::id_ex_t           id_ex,
    input  mips_pipe_pkg::ex_me_t           ex_me,
    input  mips_pipe_pkg::me_wb_t           me_wb,
    output logic                            stall,
    output mips_pipe_pkg::fwd_sel_e         id_rs_sel,
    output mips_pipe_pkg::fwd_sel_e         id_rt_sel,
    output mips_pipe_pkg::fwd_sel_e         ex_rs_sel,
    output mips_pipe_pkg::fwd_sel_e         ex_rt_sel,
    output logic                            store_fwd
);

    logic [`MIPS_REG_ADDR_WIDTH-1:0] ex_dest;
    logic                            rs_hit_ex;  // ID rs produced by EX
    logic                            rt_hit_ex;
    logic                            rs_hit_me;
    logic                            rt_hit_me;
    logic                            load_use;
    logic                            branch_wait;

    // r0 never matches, so it never forwards or stalls
    function automatic logic hits(
        input logic [`MIPS_REG_ADDR_WIDTH-1:0] src,
        input logic [`MIPS_REG_ADDR_WIDTH-1:0] dest
    );
        return (src != '0) && (src == dest);
    endfunction

    // ME is skipped for loads, the data only exists in WB
    function automatic mips_pipe_pkg::fwd_sel_e pick(
        input logic [`MIPS_REG_ADDR_WIDTH-1:0] src
    );
        if (ex_me.reg_write && !ex_me.mem_read && hits(src, ex_me.dest)) begin
            return mips_pipe_pkg::FWD_ME;
        end
        if (me_wb.reg_write && hits(src, me_wb.dest)) begin
            return mips_pipe_pkg::FWD_WB;
        end
        return mips_pipe_pkg::FWD_REG;
    endfunction

    always_comb begin
        id_rs_sel = pick(id_rs);
        id_rt_sel = pick(id_rt);
        ex_rs_sel = pick(id_ex.rs);
        ex_rt_sel = pick(id_ex.rt);
    end

    assign ex_dest   = id_ex.ctrl.dest_is_rd ? id_ex.rd : id_ex.rt;
    assign rs_hit_ex = id_ctrl.reads_rs && hits(id_rs, ex_dest);
    assign rt_hit_ex = id_ctrl.reads_rt && hits(id_rt, ex_dest);
    assign rs_hit_me = id_ctrl.reads_rs && hits(id_rs, ex_me.dest);
    assign rt_hit_me = id_ctrl.reads_rt && hits(id_rt, ex_me.dest);

    // Store rt is exempt, it is patched later in ME
    assign load_use = id_ex.ctrl.mem_read && (rs_hit_ex || (rt_hit_ex && !id_ctrl.mem_write));

    assign branch_wait = id_ctrl.is_branch &&
                         ((id_ex.ctrl.reg_write && (rs_hit_ex || rt_hit_ex)) ||
                          (ex_me.mem_read && (rs_hit_me || rt_hit_me)));

    assign stall = load_use | branch_wait;

    assign store_fwd = ex_me.mem_write && me_wb.reg_write && hits(ex_me.dest, me_wb.dest);

endmodule

//--- logic/mips_isa_pkg.sv
`include "mips_consts.svh"

package mips_isa_pkg;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, // R-type, operation in funct
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    // R-type layout; immediate is bits 15:0, jump index bits 25:0
    typedef struct packed {
        opcode_e                         opcode;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                      shamt; // Part of the immediate here
        funct_e                          funct;
    } instr_t;

endpackage

//--- logic/mips_pipe_pkg.sv
`include "mips_consts.svh"

package mips_pipe_pkg;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

    typedef enum logic [1:0] {FWD_REG, FWD_ME, FWD_WB} fwd_sel_e; // Operand source

    // All zero is a bubble
    typedef struct packed {
        logic    reads_rs;
        logic    reads_rt;
        logic    is_branch;  // BEQ or BNE, compared in ID
        logic    alu_src;    // Immediate as ALU operand B
        logic    dest_is_rd; // R-type writes rd, others rt
        alu_op_e alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                           ctrl;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rs;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rt;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] rd;
        logic [`MIPS_DATA_WIDTH-1:0]     rs_value; // Already forwarded in ID
        logic [`MIPS_DATA_WIDTH-1:0]     rt_value;
        logic [`MIPS_DATA_WIDTH-1:0]     imm_ext;
    } id_ex_t;

    typedef struct packed {
        logic                            mem_read;
        logic                            mem_write;
        logic                            reg_write;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] dest;       // rt for a store
        logic [`MIPS_DATA_WIDTH-1:0]     alu_result; // Also the memory address
        logic [`MIPS_DATA_WIDTH-1:0]     store_data;
    } ex_me_t;

    typedef struct packed {
        logic                            mem_to_reg;
        logic                            reg_write;
        logic [`MIPS_REG_ADDR_WIDTH-1:0] dest;
        logic [`MIPS_DATA_WIDTH-1:0]     mem_data;
        logic [`MIPS_DATA_WIDTH-1:0]     alu_result;
    } me_wb_t;

    typedef struct packed {
        logic [`MIPS_DATA_WIDTH-1:0] addr;
        logic [`MIPS_DATA_WIDTH-1:0] wdata;
        logic                        write;
        logic                        read;
    } dmem_req_t;

    // Operand mux shared by the ID and EX bypass paths
    function automatic logic [`MIPS_DATA_WIDTH-1:0] fwd_mux(
        input fwd_sel_e                    sel,
        input logic [`MIPS_DATA_WIDTH-1:0] reg_value,
        input logic [`MIPS_DATA_WIDTH-1:0] me_value,
        input logic [`MIPS_DATA_WIDTH-1:0] wb_value
    );
        case (sel)
            FWD_ME:  return me_value;
            FWD_WB:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

endpackage

//--- logic/mips_regfile.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module mips_regfile (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] rt_addr,
    output logic [`MIPS_DATA_WIDTH-1:0]     rs_data,
    output logic [`MIPS_DATA_WIDTH-1:0]     rt_data,
    input  logic                            wr_en,
    input  logic [`MIPS_REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`MIPS_DATA_WIDTH-1:0]     wr_data
);

    logic [`MIPS_DATA_WIDTH-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin // r0 stays zero
            regs[wr_addr] <= wr_data;
        end
    end

    // Old value during a same-cycle write, ID bypasses WB for that case
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator and run; pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_top -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Testbench passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- verification/tb_checker.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module tb_checker (
    input  logic                        clock,
    input  logic                        reset,
    input  mips_pipe_pkg::dmem_req_t    dmem_req,
    input  logic [`MIPS_DATA_WIDTH-1:0] exp_addr [256], // Expected stores in order
    input  logic [`MIPS_DATA_WIDTH-1:0] exp_data [256],
    input  int                          exp_count,
    output int                          seen,           // Stores matched so far this test
    output int                          errors          // Running total over all tests
);

    int bad;

    initial begin
        seen   = 0;
        errors = 0;
    end

    // Sampled at the edge that commits the store
    always @(posedge clock) begin
        bad = 0;
        if (reset) begin
            seen <= 0;
        end else if (dmem_req.write) begin
            if (seen >= exp_count) begin
                $display("Extra store to address %h with data %h, none was expected",
                         dmem_req.addr, dmem_req.wdata);
                errors <= errors + 1;
            end else begin
                if (dmem_req.addr !== exp_addr[seen]) begin
                    $display("[FAIL] dmem_addr store %0d: expected %h, got %h",
                             seen, exp_addr[seen], dmem_req.addr);
                    bad++;
                end
                if (dmem_req.wdata !== exp_data[seen]) begin
                    $display("[FAIL] dmem_wdata store %0d: expected %h, got %h",
                             seen, exp_data[seen], dmem_req.wdata);
                    bad++;
                end
                errors <= errors + bad;
                seen   <= seen + 1;
            end
        end
    end

endmodule

//--- verification/tb_top.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module tb_top;

    logic                        clock;
    logic                        reset;
    logic [`MIPS_DATA_WIDTH-1:0] imem_addr;
    logic [`MIPS_DATA_WIDTH-1:0] imem_data;
    mips_pipe_pkg::dmem_req_t    dmem_req;
    logic [`MIPS_DATA_WIDTH-1:0] dmem_rdata;
    logic [31:0]                 rom [256];
    logic [31:0]                 dram [256];
    logic [31:0]                 exp_addr [256];
    logic [31:0]                 exp_data [256];
    int                          exp_count;
    int                          seen;
    int                          errors;
    int                          prog_len;
    int                          cycles;
    int                          limit;  // Grows with each test's reference length
    int                          tests;
    integer                      seed;
    logic [31:0]                 rnd;
    int                          rs;
    int                          rt;
    int                          rd;

    mips_core dut (
        .clock      (clock),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    tb_checker chk (
        .clock     (clock),
        .reset     (reset),
        .dmem_req  (dmem_req),
        .exp_addr  (exp_addr),
        .exp_data  (exp_data),
        .exp_count (exp_count),
        .seen      (seen),
        .errors    (errors)
    );

    always #50 clock = ~clock;

    // Both memories answer in the same cycle
    assign imem_data  = rom[imem_addr[9:2]];
    assign dmem_rdata = dmem_req.read ? dram[dmem_req.addr[9:2]] : '1; // Junk unless read

    always @(posedge clock) begin
        if (dmem_req.write) begin
            dram[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, expected stores never arrived", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_instr(input logic [5:0] fn, input int s, t, d);
        return {6'h00, 5'(s), 5'(t), 5'(d), 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_instr(input logic [5:0] op, input int s, t,
                                            input logic [15:0] imm);
        return {op, 5'(s), 5'(t), imm};
    endfunction

    task automatic emit(input logic [31:0] ins);
        rom[prog_len] = ins;
        prog_len++;
    endtask

    // ISA model with one delay slot, records every store in order
    function automatic int mips_ref();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        int          steps;
        for (int i = 0; i < 256; i++) mem[i] = dram[i];
        for (int i = 0; i < 32; i++) regs[i] = '0;
        exp_count = 0;
        pc        = `MIPS_RESET_PC;
        npc       = pc + 4;
        steps     = 0;
        while (steps < 1000) begin
            ins = rom[pc[9:2]];
            if (ins[31:26] == mips_isa_pkg::OP_J && ins[25:0] == pc[27:2]) break; // End marker
            steps++;
            nnpc = npc + 4;
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            sx   = {{16{ins[15]}}, ins[15:0]};
            zx   = {16'h0000, ins[15:0]};
            case (ins[31:26])
                mips_isa_pkg::OP_SPECIAL: begin
                    case (ins[5:0])
                        mips_isa_pkg::FN_ADDU: regs[ins[15:11]] = a + b;
                        mips_isa_pkg::FN_SUBU: regs[ins[15:11]] = a - b;
                        mips_isa_pkg::FN_AND:  regs[ins[15:11]] = a & b;
                        mips_isa_pkg::FN_OR:   regs[ins[15:11]] = a | b;
                        mips_isa_pkg::FN_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: ; // NOP
                    endcase
                end
                mips_isa_pkg::OP_ADDIU: regs[ins[20:16]] = a + sx;
                mips_isa_pkg::OP_ANDI:  regs[ins[20:16]] = a & zx;
                mips_isa_pkg::OP_ORI:   regs[ins[20:16]] = a | zx;
                mips_isa_pkg::OP_LW:    regs[ins[20:16]] = mem[(a + sx) >> 2 & 255];
                mips_isa_pkg::OP_SW: begin
                    mem[(a + sx) >> 2 & 255] = b;
                    exp_addr[exp_count]      = a + sx;
                    exp_data[exp_count]      = b;
                    exp_count++;
                end
                mips_isa_pkg::OP_BEQ: if (a == b) nnpc = pc + 4 + (sx << 2);
                mips_isa_pkg::OP_BNE: if (a != b) nnpc = pc + 4 + (sx << 2);
                mips_isa_pkg::OP_J:   nnpc = {npc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = '0;
            pc      = npc;
            npc     = nnpc;
        end
        return steps;
    endfunction

    // Reset goes high first so the old program cannot run on the new memories
    task automatic begin_test();
        reset <= 1'b1;
        @(posedge clock);
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i]  = '0;
            dram[i] = i * 32'h9e37_79b9 + 32'h1234_5677;
        end
    endtask

    task automatic run_test(input string name);
        int n;
        int errs_before;
        emit({mips_isa_pkg::OP_J, 26'(prog_len)}); // Spin here
        emit('0);
        n           = mips_ref();
        limit       = limit + 3 * n + 30;
        errs_before = errors;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        while (seen < exp_count) @(posedge clock);
        repeat (10) @(posedge clock);
        tests++;
        $display("%s: %0d of %0d stores seen, %0d errors", name, seen, exp_count,
                 errors - errs_before);
    endtask

    initial begin
        clock  = 1'b0;
        reset  = 1'b1;
        cycles = 0;
        limit  = 0;
        tests  = 0;
        seed   = 32'h8b0a_5522;

        begin_test(); // ALU chain, forwarding from ME and WB
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 1, 16'd5));
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 1, 2, 16'd7));
        emit(r_instr(mips_isa_pkg::FN_ADDU, 1, 2, 3));
        emit(r_instr(mips_isa_pkg::FN_SUBU, 3, 1, 4));
        emit(r_instr(mips_isa_pkg::FN_SLT, 1, 4, 5));
        emit(r_instr(mips_isa_pkg::FN_OR, 4, 2, 6));
        emit(r_instr(mips_isa_pkg::FN_AND, 6, 3, 7));
        for (int k = 1; k < 8; k++) emit(i_instr(mips_isa_pkg::OP_SW, 0, k, 16'(4 * k)));
        run_test("alu_forwarding");

        begin_test(); // Load then immediate use
        emit(i_instr(mips_isa_pkg::OP_LW, 0, 1, 16'h0040));
        emit(r_instr(mips_isa_pkg::FN_ADDU, 1, 1, 2));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 2, 16'h0080));
        run_test("load_use");

        begin_test(); // Store data taken from WB in ME
        emit(i_instr(mips_isa_pkg::OP_LW, 0, 1, 16'h0044));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 1, 16'h0084));
        run_test("load_store_copy");

        begin_test(); // Branch offsets count words from the delay slot
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 1, 16'd3));
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 2, 16'd3));
        emit(i_instr(mips_isa_pkg::OP_BEQ, 1, 2, 16'd2));   // Taken
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 1, 16'h0090));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 2, 16'h0094));
        emit(i_instr(mips_isa_pkg::OP_LW, 0, 3, 16'h0040));
        emit(i_instr(mips_isa_pkg::OP_BNE, 3, 0, 16'd2));   // On a fresh load
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 4, 16'd9));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 4, 16'h0098));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 4, 16'h009c));
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 5, 16'd3));
        emit(i_instr(mips_isa_pkg::OP_BEQ, 5, 0, 16'd6));   // Not taken
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 7, 16'd3)); // Delay slot that sets the BNE operand
        emit(i_instr(mips_isa_pkg::OP_BNE, 7, 5, 16'd4));   // Not taken on a fresh result
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 3, 16'h00a4));
        emit({mips_isa_pkg::OP_J, 26'd18});
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 6, 16'd1)); // Jump delay slot
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 6, 16'h00a8));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 6, 16'h00ac));
        run_test("branches");

        begin_test(); // Random ops over r1 to r7
        for (int k = 1; k < 8; k++) begin
            rnd = $random(seed);
            emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, k, rnd[15:0]));
        end
        for (int k = 0; k < 20; k++) begin
            rnd = $random(seed);
            rs  = 1 + rnd[10:8] % 7;
            rt  = 1 + rnd[13:11] % 7;
            rd  = 1 + rnd[18:16] % 7;
            case (rnd[2:0])
                3'd0: emit(r_instr(mips_isa_pkg::FN_ADDU, rs, rt, rd));
                3'd1: emit(r_instr(mips_isa_pkg::FN_SUBU, rs, rt, rd));
                3'd2: emit(r_instr(mips_isa_pkg::FN_AND, rs, rt, rd));
                3'd3: emit(r_instr(mips_isa_pkg::FN_OR, rs, rt, rd));
                3'd4: emit(r_instr(mips_isa_pkg::FN_SLT, rs, rt, rd));
                3'd5: emit(i_instr(mips_isa_pkg::OP_ADDIU, rs, rd, rnd[31:16]));
                3'd6: emit(i_instr(mips_isa_pkg::OP_ANDI, rs, rd, rnd[31:16]));
                default: emit(i_instr(mips_isa_pkg::OP_ORI, rs, rd, rnd[31:16]));
            endcase
            emit(i_instr(mips_isa_pkg::OP_SW, 0, rd, 16'(32'h100 + 4 * k)));
        end
        run_test("random_alu");

        begin_test(); // r0 ignores writes
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 1, 16'd7));
        emit(i_instr(mips_isa_pkg::OP_ADDIU, 0, 0, 16'h0055));
        emit(r_instr(mips_isa_pkg::FN_ADDU, 1, 1, 0));
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 0, 16'h00c0)); // Bypass must not pick up r0
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 1, 16'h00c4));
        emit('0);
        emit(i_instr(mips_isa_pkg::OP_SW, 0, 0, 16'h00c8)); // Read from the file after both writes
        run_test("zero_register");

        $display("%0d tests run, %0d errors in total", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/mips_decode.sv
logic/mips_regfile.sv
logic/mips_hazard.sv
logic/mips_execute.sv
logic/mips_core.sv
verification/tb_checker.sv
verification/tb_top.sv
